// ==== common/lsu_pkg.sv ====
// load/store unit shared widths, queue depth, access size encoding
// and the payload structs carried by the two request queues
package lsu_pkg;

    // address and data path
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int OFFSET_W = 2;

    // writeback tagging
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // request queues
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;

    // access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    // everything a load needs when its read data comes back
    typedef struct packed {
        mem_size_e               size;
        logic                    is_unsigned;
        logic [OFFSET_W-1:0]     offset;
        logic [REG_ADDR_W-1:0]   rd_addr;
        logic [COMMIT_ID_W-1:0]  commit_id;
    } load_tag_t;

    // one lane-aligned write beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } store_beat_t;

endpackage

// ==== common/lsu_queue_if.sv ====
// push/pop handshake between a request queue, its producer and its consumer
`timescale 1ns/1ns

interface lsu_queue_if #(
    parameter type payload_t = logic
) ();

    // producer side
    logic     push;
    payload_t push_data;
    logic     full;

    // consumer side
    payload_t head;
    logic     empty;
    logic     pop;

    modport producer (
        output push,
        output push_data,
        input  full
    );

    modport queue (
        input  push,
        input  push_data,
        output full,
        output head,
        output empty,
        input  pop
    );

    modport consumer (
        input  head,
        input  empty,
        output pop
    );

endinterface

// ==== lsu/lsu_req_queue.sv ====
// in-order request queue, circular buffer with per-entry valid bits
`timescale 1ns/1ns

module lsu_req_queue
    import lsu_pkg::*;
#(
    parameter type payload_t = logic
) (
    input logic         clk,
    input logic         rst_n,
    lsu_queue_if.queue  q
);

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_DEPTH-1:0] entry_valid;
    payload_t               entries [QUEUE_DEPTH];

    logic push_en;
    logic pop_en;

    // pointers meet both when empty and when full, the valid bit tells which
    assign q.full  = (wr_ptr == rd_ptr) && entry_valid[wr_ptr];
    assign q.empty = (wr_ptr == rd_ptr) && !entry_valid[rd_ptr];
    assign q.head  = entries[rd_ptr];

    assign push_en = q.push && !q.full;
    assign pop_en  = q.pop && !q.empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // set on write, clear on read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else begin
            if (pop_en) begin
                entry_valid[rd_ptr] <= 1'b0;
            end
            if (push_en) begin
                entry_valid[wr_ptr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            entries[wr_ptr] <= q.push_data;
        end
    end

endmodule

// ==== lsu/lsu_issue.sv ====
// address generation, store lane alignment, read/write address issue,
// queue push and request stall
`timescale 1ns/1ns

module lsu_issue
    import lsu_pkg::*;
(
    input  logic                   req_i,
    input  logic                   load_i,
    input  logic                   store_i,
    input  mem_size_e              size_i,
    input  logic                   unsigned_i,
    input  logic [DATA_W-1:0]      op1_i,
    input  logic [DATA_W-1:0]      op2_i,
    input  logic [DATA_W-1:0]      rs2_data_i,
    input  logic [REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    input  logic                   arready_i,
    input  logic                   awready_i,

    output logic [ADDR_W-1:0]      araddr_o,
    output logic                   arvalid_o,
    output logic [ADDR_W-1:0]      awaddr_o,
    output logic                   awvalid_o,
    output logic                   stall_o,

    lsu_queue_if.producer          load_q,
    lsu_queue_if.producer          store_q
);

    logic [ADDR_W-1:0]   mem_addr;
    logic [OFFSET_W-1:0] offset;
    logic                load_req;
    logic                store_req;
    load_tag_t           tag;
    store_beat_t         beat;

    assign mem_addr = op1_i + op2_i;
    assign offset   = mem_addr[OFFSET_W-1:0];

    assign load_req  = req_i && load_i;
    assign store_req = req_i && store_i;

    // load tag captured at address handshake
    always_comb begin
        tag.size        = size_i;
        tag.is_unsigned = unsigned_i;
        tag.offset      = offset;
        tag.rd_addr     = rd_addr_i;
        tag.commit_id   = commit_id_i;
    end

    // move the low part of rs2 into the addressed lanes
    always_comb begin
        case (size_i)
            SIZE_BYTE: begin
                beat.data = DATA_W'(rs2_data_i[7:0]) << {offset, 3'b000};
                beat.strb = STRB_W'(1'b1) << offset;
            end
            SIZE_HALF: begin
                beat.data = DATA_W'(rs2_data_i[15:0]) << {offset[1], 4'b0000};
                beat.strb = STRB_W'(2'b11) << {offset[1], 1'b0};
            end
            default: begin
                beat.data = rs2_data_i;
                beat.strb = {STRB_W{1'b1}};
            end
        endcase
    end

    // no address goes out unless its queue has room
    assign arvalid_o = load_req && !load_q.full;
    assign awvalid_o = store_req && !store_q.full;
    assign araddr_o  = mem_addr;
    assign awaddr_o  = mem_addr;

    // one queue entry per completed address handshake
    assign load_q.push      = arvalid_o && arready_i;
    assign load_q.push_data = tag;

    assign store_q.push      = awvalid_o && awready_i;
    assign store_q.push_data = beat;

    // hold the request until both queue and address channel accept it
    assign stall_o = (load_req && (load_q.full || !arready_i))
                   || (store_req && (store_q.full || !awready_i));

endmodule

// ==== lsu/lsu_load_align.sv ====
// read data extraction, sign or zero extension and registered writeback
`timescale 1ns/1ns

module lsu_load_align
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [DATA_W-1:0]      rdata_i,
    input  logic                   rvalid_i,

    output logic                   reg_we_o,
    output logic [REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [DATA_W-1:0]      reg_wdata_o,
    output logic [COMMIT_ID_W-1:0] commit_id_o,

    lsu_queue_if.consumer          load_q
);

    load_tag_t         tag;
    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    logic              sign_bit;
    logic [DATA_W-1:0] load_data;

    // data returns in order, so the head tag belongs to this beat
    assign tag        = load_q.head;
    assign load_q.pop = rvalid_i && !load_q.empty;

    // byte by full offset, half-word by upper offset bit
    assign byte_sel = rdata_i[{tag.offset, 3'b000} +: 8];
    assign half_sel = rdata_i[{tag.offset[1], 4'b0000} +: 16];

    always_comb begin
        case (tag.size)
            SIZE_BYTE: begin
                sign_bit  = byte_sel[7] && !tag.is_unsigned;
                load_data = {{(DATA_W - 8){sign_bit}}, byte_sel};
            end
            SIZE_HALF: begin
                sign_bit  = half_sel[15] && !tag.is_unsigned;
                load_data = {{(DATA_W - 16){sign_bit}}, half_sel};
            end
            default: begin
                sign_bit  = 1'b0;
                load_data = rdata_i;
            end
        endcase
    end

    // write enable pulses one cycle after each read beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_we_o <= 1'b0;
        end else begin
            reg_we_o <= rvalid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid_i) begin
            reg_wdata_o <= load_data;
            reg_waddr_o <= tag.rd_addr;
            commit_id_o <= tag.commit_id;
        end
    end

endmodule

// ==== verilog/lsu_top.sv ====
// load/store unit top level: issue, load and store queues, load alignment
// and the write-data channel
`timescale 1ns/1ns

module lsu_top
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // request from execute
    input  logic                   req_i,
    input  logic                   load_i,
    input  logic                   store_i,
    input  mem_size_e              size_i,
    input  logic                   unsigned_i,
    input  logic [DATA_W-1:0]      op1_i,
    input  logic [DATA_W-1:0]      op2_i,
    input  logic [DATA_W-1:0]      rs2_data_i,
    input  logic [REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    output logic                   stall_o,
    output logic                   busy_o,

    // read address and data
    output logic [ADDR_W-1:0]      araddr_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    input  logic [DATA_W-1:0]      rdata_i,
    input  logic                   rvalid_i,
    output logic                   rready_o,

    // write address, data and response
    output logic [ADDR_W-1:0]      awaddr_o,
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output logic [DATA_W-1:0]      wdata_o,
    output logic [STRB_W-1:0]      wstrb_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    output logic                   bready_o,

    // register file writeback
    output logic                   reg_we_o,
    output logic [REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [DATA_W-1:0]      reg_wdata_o,
    output logic [COMMIT_ID_W-1:0] commit_id_o
);

    lsu_queue_if #(.payload_t(load_tag_t))   load_q_if ();
    lsu_queue_if #(.payload_t(store_beat_t)) store_q_if ();

    lsu_issue issue_i (
        .req_i       (req_i),
        .load_i      (load_i),
        .store_i     (store_i),
        .size_i      (size_i),
        .unsigned_i  (unsigned_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_i   (rd_addr_i),
        .commit_id_i (commit_id_i),
        .arready_i   (arready_i),
        .awready_i   (awready_i),
        .araddr_o    (araddr_o),
        .arvalid_o   (arvalid_o),
        .awaddr_o    (awaddr_o),
        .awvalid_o   (awvalid_o),
        .stall_o     (stall_o),
        .load_q      (load_q_if.producer),
        .store_q     (store_q_if.producer)
    );

    lsu_req_queue #(.payload_t(load_tag_t)) load_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (load_q_if.queue)
    );

    lsu_req_queue #(.payload_t(store_beat_t)) store_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (store_q_if.queue)
    );

    lsu_load_align load_align_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rdata_i     (rdata_i),
        .rvalid_i    (rvalid_i),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .commit_id_o (commit_id_o),
        .load_q      (load_q_if.consumer)
    );

    // store queue head drives the write-data channel directly
    assign wvalid_o       = !store_q_if.empty;
    assign wdata_o        = store_q_if.head.data;
    assign wstrb_o        = store_q_if.head.strb;
    assign store_q_if.pop = wready_i && !store_q_if.empty;

    // busy while any store beat has not left yet
    assign busy_o = !store_q_if.empty;

    // read data and write responses are always accepted,
    // bvalid_i carries nothing the unit needs
    assign rready_o = 1'b1;
    assign bready_o = 1'b1;

endmodule

// ==== verification/lsu_assertions.sv ====
// concurrent protocol checks on the load/store unit top level,
// attached to lsu_top with bind
`timescale 1ns/1ns

module lsu_assertions
    import lsu_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic arvalid_i,
    input logic arready_i,
    input logic awvalid_i,
    input logic awready_i,
    input logic wvalid_i,
    input logic wready_i,
    input logic load_empty_i,
    input logic rvalid_i,
    input logic reg_we_i
);

    // queue occupancy counted from the bus handshakes
    logic [QUEUE_PTR_W:0] loads_held;
    logic [QUEUE_PTR_W:0] stores_held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loads_held  <= '0;
            stores_held <= '0;
        end else begin
            loads_held  <= loads_held + (arvalid_i && arready_i) - rvalid_i;
            stores_held <= stores_held + (awvalid_i && awready_i) - (wvalid_i && wready_i);
        end
    end

    // no address goes out towards a full queue
    ar_needs_room: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i |-> (loads_held < QUEUE_DEPTH))
        else $error("arvalid_o high while the load queue is full");

    aw_needs_room: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i |-> (stores_held < QUEUE_DEPTH))
        else $error("awvalid_o high while the store queue is full");

    // every read beat must have a tag waiting
    r_has_tag: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i |-> !load_empty_i)
        else $error("rvalid_i arrived with the load queue empty");

    // back-to-back writebacks only follow back-to-back read beats
    we_follows_r: assert property (@(posedge clk) disable iff (!rst_n)
        (reg_we_i && $past(reg_we_i)) |-> ($past(rvalid_i) && $past(rvalid_i, 2)))
        else $error("reg_we_o high twice without two read beats before it");

endmodule

bind lsu_top lsu_assertions assertions_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .arvalid_i    (arvalid_o),
    .arready_i    (arready_i),
    .awvalid_i    (awvalid_o),
    .awready_i    (awready_i),
    .wvalid_i     (wvalid_o),
    .wready_i     (wready_i),
    .load_empty_i (load_q_if.empty),
    .rvalid_i     (rvalid_i),
    .reg_we_i     (reg_we_o)
);

// ==== verification/tb_lsu_top.sv ====
// testbench for the load/store unit: bus memory model, reference functions,
// directed stimulus, writeback and write-beat checker, cycle limit
`timescale 1ns/1ns

module tb_lsu_top;
    import lsu_pkg::*;

    // roughly five times the length of all tests
    localparam int MAX_CYCLES = 4000;

    logic clk = 1'b0;
    logic rst_n;
    logic req_i, load_i, store_i, unsigned_i;
    mem_size_e size_i;
    logic [DATA_W-1:0] op1_i, op2_i, rs2_data_i, rdata_i, wdata_o, reg_wdata_o;
    logic [ADDR_W-1:0] araddr_o, awaddr_o;
    logic [REG_ADDR_W-1:0] rd_addr_i, reg_waddr_o;
    logic [COMMIT_ID_W-1:0] commit_id_i, commit_id_o;
    logic [STRB_W-1:0] wstrb_o;
    logic stall_o, busy_o, arvalid_o, arready_i, rvalid_i, rready_o;
    logic awvalid_o, awready_i, wvalid_o, wready_i, bvalid_i, bready_o, reg_we_o;

    // memory model state, ready modes are 0 random, 1 high, 2 low
    logic [31:0] mem [64];
    logic [31:0] rd_addr_q [$];
    logic [31:0] aw_addr_q [$];
    int          rd_due_q [$];
    integer      seed = 32'hd9b3_a6a0;
    int          mem_cycle = 0;
    int          last_due = 0;
    int          ar_ctl, aw_ctl, w_ctl;
    logic        rd_hold;

    // checker state, writeback entries are {rd, commit id, data}
    logic [39:0] exp_load_q [$];
    logic [35:0] exp_beat_q [$];
    string       test_name;
    int          error_count = 0;
    int          cycle_count = 0;
    logic [7:0]  req_count = 0;
    logic [31:0] cur_addr;

    lsu_top lsu_top_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] ref_load(input logic [31:0] word, input mem_size_e size,
                                             input logic is_unsigned, input logic [1:0] offset);
        logic [31:0] shifted;
        if (size == SIZE_BYTE) begin
            shifted = word >> (8 * offset);
            return is_unsigned ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
        end
        if (size == SIZE_HALF) begin
            shifted = word >> (16 * offset[1]);
            return is_unsigned ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
        end
        return word;
    endfunction

    // expected {data, strb} of a store beat, unused lanes zero
    function automatic logic [35:0] ref_store(input logic [31:0] data, input mem_size_e size,
                                              input logic [1:0] offset);
        logic [31:0] lanes;
        logic [3:0]  strb;
        int          first;
        int          count;
        lanes = '0;
        strb  = '0;
        first = 0;
        count = 4;
        if (size == SIZE_BYTE) begin
            first = offset;
            count = 1;
        end else if (size == SIZE_HALF) begin
            first = {offset[1], 1'b0};
            count = 2;
        end
        for (int i = 0; i < 4; i++) begin
            if (i >= first && i < first + count) begin
                strb[i] = 1'b1;
                lanes[8*i +: 8] = data[8*(i-first) +: 8];
            end
        end
        return {lanes, strb};
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    function automatic logic ready_pick(input int mode, input logic rnd);
        if (mode == 1) return 1'b1;
        if (mode == 2) return 1'b0;
        return rnd;
    endfunction

    task automatic fail_run(input string why);
        error_count++;
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else fail_run($sformatf("FAILED %s %s: expected %h actual %h",
                                test_name, what, expected, actual));
    endtask

    task automatic check_true(input logic cond, input string why);
        assert (cond === 1'b1)
        else fail_run($sformatf("%s in test %s", why, test_name));
    endtask

    // AR/AW/W ready, in-order read data with 1 to 3 cycles latency
    always @(posedge clk) begin : memory_model
        int          lat;
        int          ar_mode;
        int          aw_mode;
        int          w_mode;
        logic        hold;
        logic [31:0] addr;
        logic [31:0] r;
        ar_mode = ar_ctl;
        aw_mode = aw_ctl;
        w_mode  = w_ctl;
        hold    = rd_hold;
        mem_cycle++;
        if (arvalid_o && arready_i) begin
            lat = 1 + {$random(seed)} % 3;
            last_due = (mem_cycle + lat - 1 > last_due) ? mem_cycle + lat - 1 : last_due + 1;
            rd_due_q.push_back(last_due);
            rd_addr_q.push_back(araddr_o);
        end
        if (awvalid_o && awready_i) begin
            aw_addr_q.push_back(awaddr_o);
        end
        if (wvalid_o && wready_i) begin
            if (aw_addr_q.size() == 0) begin
                fail_run("write beat arrived before its write address");
            end else begin
                addr = aw_addr_q.pop_front();
                for (int i = 0; i < 4; i++) begin
                    if (wstrb_o[i]) mem[addr[7:2]][8*i +: 8] = wdata_o[8*i +: 8];
                end
            end
        end
        #1;
        r = $random(seed);
        arready_i = ready_pick(ar_mode, r[0]);
        awready_i = ready_pick(aw_mode, r[1]);
        wready_i  = ready_pick(w_mode, r[2]);
        if (!hold && rd_due_q.size() > 0 && rd_due_q[0] <= mem_cycle) begin
            addr = rd_addr_q.pop_front();
            void'(rd_due_q.pop_front());
            rvalid_i = 1'b1;
            rdata_i  = mem[addr[7:2]];
        end else begin
            rvalid_i = 1'b0;
            rdata_i  = $random(seed);
        end
    end

    // compares writebacks and write beats with the expected queues
    always @(posedge clk) begin : compare
        logic [39:0] exp_wb;
        logic [35:0] exp_beat;
        if (rst_n && reg_we_o) begin
            if (exp_load_q.size() == 0) begin
                fail_run("register writeback without an outstanding load");
            end else begin
                exp_wb = exp_load_q.pop_front();
                check_value("rd", exp_wb[39:35], reg_waddr_o);
                check_value("commit id", exp_wb[34:32], commit_id_o);
                check_value("load data", exp_wb[31:0], reg_wdata_o);
            end
        end
        if (rst_n && wvalid_o && wready_i) begin
            if (exp_beat_q.size() == 0) begin
                fail_run("write beat without an outstanding store");
            end else begin
                exp_beat = exp_beat_q.pop_front();
                check_value("wstrb", exp_beat[3:0], wstrb_o);
                check_value("wdata", exp_beat[35:4], wdata_o & lane_mask(exp_beat[3:0]));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) fail_run("timeout, the tests did not finish in time");
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_req(input logic is_load, input mem_size_e size, input logic uns,
                             input logic [31:0] addr, input logic [31:0] data);
        cur_addr    = addr;
        req_i       = 1'b1;
        load_i      = is_load;
        store_i     = !is_load;
        size_i      = size;
        unsigned_i  = uns;
        op1_i       = 32'h1357_0000 ^ {req_count, 4'h0};
        op2_i       = addr - op1_i;
        rs2_data_i  = data;
        rd_addr_i   = req_count[4:0];
        commit_id_i = req_count[2:0];
    endtask

    // holds the request until stall_o is low at a clock edge
    task automatic wait_accept();
        do @(posedge clk); while (stall_o);
        if (load_i) begin
            exp_load_q.push_back({rd_addr_i, commit_id_i,
                ref_load(mem[cur_addr[7:2]], size_i, unsigned_i, cur_addr[1:0])});
        end else begin
            exp_beat_q.push_back(ref_store(rs2_data_i, size_i, cur_addr[1:0]));
        end
        #1;
        req_i   = 1'b0;
        load_i  = 1'b0;
        store_i = 1'b0;
        req_count++;
    endtask

    task automatic do_req(input logic is_load, input mem_size_e size, input logic uns,
                          input logic [31:0] addr, input logic [31:0] data);
        drive_req(is_load, size, uns, addr, data);
        wait_accept();
    endtask

    task automatic wait_drain();
        do next_cycle(); while (busy_o || exp_load_q.size() != 0);
    endtask

    initial begin
        {req_i, load_i, store_i, unsigned_i} = '0;
        size_i = SIZE_WORD;
        {op1_i, op2_i, rs2_data_i, rdata_i} = '0;
        {rd_addr_i, commit_id_i} = '0;
        {arready_i, rvalid_i, awready_i, wready_i, bvalid_i} = '0;
        {ar_ctl, aw_ctl, w_ctl} = '0;
        rd_hold = 1'b0;
        // every lane has its top bit set
        for (int i = 0; i < 64; i++) mem[i] = 32'h8080_8080 | (i * 32'h0103_0507);
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        test_name = "reset_outputs";
        check_value("outputs", 32'h0, {reg_we_o, arvalid_o, awvalid_o, wvalid_o, busy_o});
        check_value("rready and bready", 32'h3, {rready_o, bready_o});

        test_name = "store_lanes";
        do_req(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'hf1e2_d3c4);
        do_req(1'b0, SIZE_HALF, 1'b0, 32'h14, 32'h1111_a5b6);
        do_req(1'b0, SIZE_HALF, 1'b0, 32'h16, 32'h2222_c7d8);
        for (int off = 0; off < 4; off++) begin
            do_req(1'b0, SIZE_BYTE, 1'b0, 32'h18 + off, 32'h90 + off);
        end
        wait_drain();
        check_value("word 4", 32'hf1e2_d3c4, mem[4]);
        check_value("word 5", 32'hc7d8_a5b6, mem[5]);
        check_value("word 6", 32'h9392_9190, mem[6]);
        for (int k = 0; k < 3; k++) do_req(1'b1, SIZE_WORD, 1'b0, 32'h10 + 4 * k, 0);

        test_name = "load_extend";
        for (int uns = 0; uns < 2; uns++) begin
            for (int off = 0; off < 4; off++) do_req(1'b1, SIZE_BYTE, uns, 32'h40 + 5 * off, 0);
            for (int off = 0; off < 4; off += 2) do_req(1'b1, SIZE_HALF, uns, 32'h60 + 5 * off, 0);
        end
        do_req(1'b1, SIZE_WORD, 1'b0, 32'h70, 0);
        do_req(1'b1, SIZE_WORD, 1'b1, 32'h74, 0);
        wait_drain();

        test_name = "load_pipeline";
        ar_ctl  = 1;
        rd_hold = 1'b1;
        next_cycle();
        for (int k = 0; k < 4; k++) do_req(1'b1, SIZE_WORD, 1'b0, 32'h80 + 4 * k, 0);
        drive_req(1'b1, SIZE_BYTE, 1'b1, 32'h91, 0);
        @(posedge clk);
        check_true(stall_o && !arvalid_o, "stall_o low with four loads in flight");
        #1 rd_hold = 1'b0;
        wait_accept();
        wait_drain();
        ar_ctl = 2;
        next_cycle();
        drive_req(1'b1, SIZE_HALF, 1'b0, 32'h86, 0);
        @(posedge clk);
        check_true(stall_o && arvalid_o, "stall_o low while arready_i is low");
        #1 ar_ctl = 0;
        wait_accept();
        for (int k = 0; k < 6; k++) do_req(1'b1, SIZE_BYTE, k[0], 32'ha0 + 3 * k, 0);
        wait_drain();

        test_name = "store_fill";
        w_ctl  = 2;
        aw_ctl = 1;
        next_cycle();
        for (int k = 0; k < 4; k++) begin
            do_req(1'b0, SIZE_WORD, 1'b0, 32'hc0 + 4 * k, 32'h8765_4320 + k);
        end
        check_true(busy_o, "busy_o low with store beats queued");
        drive_req(1'b0, SIZE_WORD, 1'b0, 32'hd0, 32'h8765_4324);
        @(posedge clk);
        check_true(stall_o && busy_o, "stall_o low for a fifth store");
        #1;
        w_ctl  = 0;
        aw_ctl = 0;
        wait_accept();
        wait_drain();
        for (int k = 0; k < 5; k++) check_value("stored word", 32'h8765_4320 + k, mem[48 + k]);
        for (int k = 0; k < 5; k++) do_req(1'b1, SIZE_WORD, 1'b0, 32'hc0 + 4 * k, 0);
        wait_drain();
        check_true(exp_beat_q.size() == 0, "store beats never reached the write channel");

        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/lsu_pkg.sv
common/lsu_queue_if.sv
lsu/lsu_req_queue.sv
lsu/lsu_issue.sv
lsu/lsu_load_align.sv
verilog/lsu_top.sv
verification/lsu_assertions.sv
verification/tb_lsu_top.sv
